// File: common/calc_isa_pkg.sv
// Instruction set encodings
package calc_isa_pkg;

  localparam int instr_width_c = 32;

  // Major opcodes of the supported subset
  localparam logic [6:0] opcode_op_c     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm_c = 7'b0010011;

  localparam logic [2:0] funct3_add_c = 3'b000;
  localparam logic [2:0] funct3_sll_c = 3'b001;
  localparam logic [2:0] funct3_slt_c = 3'b010;
  localparam logic [2:0] funct3_xor_c = 3'b100;
  localparam logic [2:0] funct3_srl_c = 3'b101;
  localparam logic [2:0] funct3_or_c  = 3'b110;
  localparam logic [2:0] funct3_and_c = 3'b111;
  localparam logic [2:0] funct3_mul_c = 3'b000;

  localparam logic [6:0] funct7_base_c = 7'b0000000;
  localparam logic [6:0] funct7_sub_c  = 7'b0100000;
  // M extension
  localparam logic [6:0] funct7_mul_c  = 7'b0000001;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_s;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_s;

  // One word whose field layout depends on the opcode
  typedef union packed {
    rtype_s rtype;
    itype_s itype;
  } instr_u;

endpackage

// File: common/calc_pipe_pkg.sv
// Pipeline widths and ALU codes
package calc_pipe_pkg;

  localparam int dpath_width_c    = 32;
  localparam int reg_addr_width_c = 5;
  localparam int alu_op_width_c   = 3;

  localparam logic [alu_op_width_c-1:0] alu_add_c = 3'd0;
  localparam logic [alu_op_width_c-1:0] alu_sub_c = 3'd1;
  localparam logic [alu_op_width_c-1:0] alu_and_c = 3'd2;
  localparam logic [alu_op_width_c-1:0] alu_or_c  = 3'd3;
  localparam logic [alu_op_width_c-1:0] alu_xor_c = 3'd4;
  localparam logic [alu_op_width_c-1:0] alu_slt_c = 3'd5;
  localparam logic [alu_op_width_c-1:0] alu_sll_c = 3'd6;
  localparam logic [alu_op_width_c-1:0] alu_srl_c = 3'd7;

endpackage

// File: decode/calc_issue_stage.sv
// Decode, bypass and reservation register
`timescale 1ns/1ps

module calc_issue_stage
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
  #(parameter int mul_latency_p = 3,
    localparam int comp_depth_lp = mul_latency_p + 1)
  (input  logic                                              clk_i,
   input  logic                                              rst_i,
   input  logic                                              dispatch_v_i,
   input  logic [instr_width_c-1:0]                          instr_i,
   input  logic [dpath_width_c-1:0]                          rs1_data_i,
   input  logic [dpath_width_c-1:0]                          rs2_data_i,
   input  logic                                              flush_i,
   input  logic [comp_depth_lp:1]                            fwd_v_i,
   input  logic [comp_depth_lp:1][reg_addr_width_c-1:0]      fwd_addr_i,
   input  logic [comp_depth_lp:1][dpath_width_c-1:0]         fwd_data_i,
   output logic                                              res_v_o,
   output logic [alu_op_width_c-1:0]                         res_alu_op_o,
   output logic                                              res_is_mul_o,
   output logic [reg_addr_width_c-1:0]                       res_rd_o,
   output logic [dpath_width_c-1:0]                          res_op_a_o,
   output logic [dpath_width_c-1:0]                          res_op_b_o,
   output logic                                              res_illegal_o);

  instr_u                    instr;
  logic [alu_op_width_c-1:0] alu_op;
  logic                      is_mul;
  logic                      use_imm;
  logic                      illegal;
  logic [dpath_width_c-1:0]  imm_ext;
  logic [dpath_width_c-1:0]  rs1_val;
  logic [dpath_width_c-1:0]  rs2_val;

  assign instr   = instr_i;
  assign imm_ext = {{(dpath_width_c-12){instr.itype.imm12[11]}}, instr.itype.imm12};

  always_comb
  begin
    alu_op  = alu_add_c;
    is_mul  = 1'b0;
    use_imm = 1'b0;
    illegal = 1'b0;
    case (instr.rtype.opcode)
      opcode_op_c:
      begin
        if (instr.rtype.funct7 == funct7_mul_c)
        begin
          is_mul  = (instr.rtype.funct3 == funct3_mul_c);
          illegal = (instr.rtype.funct3 != funct3_mul_c);
        end
        else if (instr.rtype.funct7 == funct7_sub_c)
        begin
          alu_op  = alu_sub_c;
          illegal = (instr.rtype.funct3 != funct3_add_c);
        end
        else if (instr.rtype.funct7 == funct7_base_c)
        begin
          case (instr.rtype.funct3)
            funct3_add_c: alu_op = alu_add_c;
            funct3_sll_c: alu_op = alu_sll_c;
            funct3_slt_c: alu_op = alu_slt_c;
            funct3_xor_c: alu_op = alu_xor_c;
            funct3_srl_c: alu_op = alu_srl_c;
            funct3_or_c:  alu_op = alu_or_c;
            funct3_and_c: alu_op = alu_and_c;
            default:      illegal = 1'b1;
          endcase
        end
        else
          illegal = 1'b1;
      end
      // Only addi from the immediate group
      opcode_op_imm_c:
      begin
        use_imm = 1'b1;
        illegal = (instr.itype.funct3 != funct3_add_c);
      end
      default: illegal = 1'b1;
    endcase
  end

  // Stage 1 is youngest so it is checked last and wins
  always_comb
  begin
    rs1_val = rs1_data_i;
    rs2_val = rs2_data_i;
    for (int s = comp_depth_lp; s >= 1; s--)
    begin
      if (fwd_v_i[s] && fwd_addr_i[s] == instr.rtype.rs1)
        rs1_val = fwd_data_i[s];
      if (fwd_v_i[s] && fwd_addr_i[s] == instr.rtype.rs2)
        rs2_val = fwd_data_i[s];
    end
    if (instr.rtype.rs1 == '0)
      rs1_val = '0;
    if (instr.rtype.rs2 == '0)
      rs2_val = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      res_v_o <= 1'b0;
    else
      res_v_o <= dispatch_v_i & ~flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    res_alu_op_o  <= alu_op;
    res_is_mul_o  <= is_mul;
    res_rd_o      <= instr.rtype.rd;
    res_op_a_o    <= rs1_val;
    res_op_b_o    <= use_imm ? imm_ext : rs2_val;
    res_illegal_o <= illegal;
  end

endmodule

// File: execute/calc_alu.sv
// Single-cycle integer ALU
`timescale 1ns/1ps

module calc_alu
  import calc_pipe_pkg::*;
  (input  logic [alu_op_width_c-1:0] res_alu_op_i,
   input  logic [dpath_width_c-1:0]  op_a_i,
   input  logic [dpath_width_c-1:0]  op_b_i,
   output logic [dpath_width_c-1:0]  result_o);

  localparam int shamt_width_lp = $clog2(dpath_width_c);

  logic [shamt_width_lp-1:0] shamt;
  logic                      lt_signed;

  assign shamt     = op_b_i[shamt_width_lp-1:0];
  assign lt_signed = $signed(op_a_i) < $signed(op_b_i);

  always_comb
  begin
    result_o = '0;
    case (res_alu_op_i)
      alu_add_c: result_o = op_a_i + op_b_i;
      alu_sub_c: result_o = op_a_i - op_b_i;
      alu_and_c: result_o = op_a_i & op_b_i;
      alu_or_c:  result_o = op_a_i | op_b_i;
      alu_xor_c: result_o = op_a_i ^ op_b_i;
      alu_slt_c: result_o = {{(dpath_width_c-1){1'b0}}, lt_signed};
      alu_sll_c: result_o = op_a_i << shamt;
      alu_srl_c: result_o = op_a_i >> shamt;
      default:   result_o = '0;
    endcase
  end

endmodule

// File: execute/calc_mul_pipe.sv
// Fixed-latency multiplier
`timescale 1ns/1ps

module calc_mul_pipe
  import calc_pipe_pkg::*;
  #(parameter int mul_latency_p = 3)
  (input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     v_i,
   input  logic [dpath_width_c-1:0] op_a_i,
   input  logic [dpath_width_c-1:0] op_b_i,
   output logic                     v_o,
   output logic [dpath_width_c-1:0] data_o);

  // The reservation register is the first cycle of the latency
  localparam int chain_depth_lp = mul_latency_p - 1;

  logic [dpath_width_c-1:0]                      product;
  logic [chain_depth_lp-1:0]                     v_r;
  logic [chain_depth_lp-1:0][dpath_width_c-1:0]  data_r;

  // Low word of the product only
  assign product = op_a_i * op_b_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      v_r <= '0;
    else
    begin
      v_r[0] <= v_i;
      for (int s = 1; s < chain_depth_lp; s++)
        v_r[s] <= v_r[s-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    data_r[0] <= product;
    for (int s = 1; s < chain_depth_lp; s++)
      data_r[s] <= data_r[s-1];
  end

  assign v_o    = v_r[chain_depth_lp-1];
  assign data_o = data_r[chain_depth_lp-1];

endmodule

// File: flist.f
common/calc_isa_pkg.sv
common/calc_pipe_pkg.sv
decode/calc_issue_stage.sv
execute/calc_alu.sv
execute/calc_mul_pipe.sv
result/calc_completion_pipe.sv
logic/calc_top.sv
testbench/calc_tb.sv

// File: logic/calc_top.sv
// Integer backend calculator
`timescale 1ns/1ps

module calc_top
  import calc_isa_pkg::*;
  import calc_pipe_pkg::*;
  #(parameter int mul_latency_p = 3)
  (input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        dispatch_v_i,
   input  logic [instr_width_c-1:0]    instr_i,
   input  logic [dpath_width_c-1:0]    rs1_data_i,
   input  logic [dpath_width_c-1:0]    rs2_data_i,
   input  logic                        flush_i,
   output logic                        wb_v_o,
   output logic [reg_addr_width_c-1:0] wb_addr_o,
   output logic [dpath_width_c-1:0]    wb_data_o,
   output logic                        illegal_o);

  localparam int comp_depth_lp = mul_latency_p + 1;

  logic                                          res_v;
  logic [alu_op_width_c-1:0]                     res_alu_op;
  logic                                          res_is_mul;
  logic [reg_addr_width_c-1:0]                   res_rd;
  logic [dpath_width_c-1:0]                      res_op_a;
  logic [dpath_width_c-1:0]                      res_op_b;
  logic                                          res_illegal;
  logic [dpath_width_c-1:0]                      alu_result;
  logic                                          mul_v;
  logic [dpath_width_c-1:0]                      mul_data;
  logic [comp_depth_lp:1]                        fwd_v;
  logic [comp_depth_lp:1][reg_addr_width_c-1:0]  fwd_addr;
  logic [comp_depth_lp:1][dpath_width_c-1:0]     fwd_data;

  calc_issue_stage #(.mul_latency_p(mul_latency_p)) issue
    (.clk_i(clk_i), .rst_i(rst_i),
     .dispatch_v_i(dispatch_v_i), .instr_i(instr_i),
     .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
     .flush_i(flush_i),
     .fwd_v_i(fwd_v), .fwd_addr_i(fwd_addr), .fwd_data_i(fwd_data),
     .res_v_o(res_v), .res_alu_op_o(res_alu_op), .res_is_mul_o(res_is_mul),
     .res_rd_o(res_rd), .res_op_a_o(res_op_a), .res_op_b_o(res_op_b),
     .res_illegal_o(res_illegal));

  calc_alu alu
    (.res_alu_op_i(res_alu_op), .op_a_i(res_op_a), .op_b_i(res_op_b),
     .result_o(alu_result));

  calc_mul_pipe #(.mul_latency_p(mul_latency_p)) mul
    (.clk_i(clk_i), .rst_i(rst_i),
     .v_i(res_v & res_is_mul), .op_a_i(res_op_a), .op_b_i(res_op_b),
     .v_o(mul_v), .data_o(mul_data));

  calc_completion_pipe #(.mul_latency_p(mul_latency_p)) completion
    (.clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
     .res_v_i(res_v), .res_is_mul_i(res_is_mul), .res_rd_i(res_rd),
     .res_illegal_i(res_illegal), .alu_result_i(alu_result),
     .mul_v_i(mul_v), .mul_data_i(mul_data),
     .fwd_v_o(fwd_v), .fwd_addr_o(fwd_addr), .fwd_data_o(fwd_data),
     .wb_v_o(wb_v_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o),
     .illegal_o(illegal_o));

endmodule

// File: result/calc_completion_pipe.sv
// Completion pipe and writeback
`timescale 1ns/1ps

module calc_completion_pipe
  import calc_pipe_pkg::*;
  #(parameter int mul_latency_p = 3,
    localparam int comp_depth_lp = mul_latency_p + 1)
  (input  logic                                          clk_i,
   input  logic                                          rst_i,
   input  logic                                          flush_i,
   input  logic                                          res_v_i,
   input  logic                                          res_is_mul_i,
   input  logic [reg_addr_width_c-1:0]                   res_rd_i,
   input  logic                                          res_illegal_i,
   input  logic [dpath_width_c-1:0]                      alu_result_i,
   input  logic                                          mul_v_i,
   input  logic [dpath_width_c-1:0]                      mul_data_i,
   output logic [comp_depth_lp:1]                        fwd_v_o,
   output logic [comp_depth_lp:1][reg_addr_width_c-1:0]  fwd_addr_o,
   output logic [comp_depth_lp:1][dpath_width_c-1:0]     fwd_data_o,
   output logic                                          wb_v_o,
   output logic [reg_addr_width_c-1:0]                   wb_addr_o,
   output logic [dpath_width_c-1:0]                      wb_data_o,
   output logic                                          illegal_o);

  logic [comp_depth_lp:1]                        v_r, v_n;
  logic [comp_depth_lp:1]                        poison_r, poison_n;
  logic [comp_depth_lp:1]                        is_mul_r, is_mul_n;
  logic [comp_depth_lp:1]                        illegal_r, illegal_n;
  logic [comp_depth_lp:1][reg_addr_width_c-1:0]  rd_r, rd_n;
  logic [comp_depth_lp:1][dpath_width_c-1:0]     data_r, data_n;
  logic                                          wb_live;

  always_comb
  begin
    v_n[1]       = res_v_i;
    poison_n[1]  = flush_i;
    is_mul_n[1]  = res_is_mul_i;
    illegal_n[1] = res_illegal_i;
    rd_n[1]      = res_rd_i;
    data_n[1]    = alu_result_i;
    for (int s = 2; s <= comp_depth_lp; s++)
    begin
      v_n[s]       = v_r[s-1];
      poison_n[s]  = poison_r[s-1];
      is_mul_n[s]  = is_mul_r[s-1];
      illegal_n[s] = illegal_r[s-1];
      rd_n[s]      = rd_r[s-1];
      data_n[s]    = data_r[s-1];
    end
    // Flush kills the two youngest entries already past issue
    poison_n[2] = poison_n[2] | flush_i;
    if (mul_v_i)
      data_n[mul_latency_p] = mul_data_i;
  end

  always_comb
  begin
    for (int s = 1; s <= comp_depth_lp; s++)
    begin
      fwd_v_o[s]    = v_n[s] & ~poison_n[s] & ~illegal_n[s] &
                      (~is_mul_n[s] | (s >= mul_latency_p));
      fwd_addr_o[s] = rd_n[s];
      fwd_data_o[s] = data_n[s];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r      <= '0;
      poison_r <= '0;
    end
    else
    begin
      v_r      <= v_n;
      poison_r <= poison_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    is_mul_r  <= is_mul_n;
    illegal_r <= illegal_n;
    rd_r      <= rd_n;
    data_r    <= data_n;
  end

  assign wb_live   = v_r[comp_depth_lp] & ~poison_r[comp_depth_lp];
  assign wb_v_o    = wb_live & ~illegal_r[comp_depth_lp] & (rd_r[comp_depth_lp] != '0);
  assign wb_addr_o = rd_r[comp_depth_lp];
  assign wb_data_o = data_r[comp_depth_lp];
  assign illegal_o = wb_live & illegal_r[comp_depth_lp];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module calc_tb -o calc_sim
./obj_dir/calc_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi

// File: testbench/calc_tb.sv
// Calculator backend testbench
`timescale 1ns/1ps

module calc_tb;

  localparam int mul_latency_c = 3;
  localparam int drain_c       = mul_latency_c + 3;
  localparam int timeout_c     = 27 + 16 + 10 + 3 * (mul_latency_c + 1) + 8 + 6
                                 + 6 * drain_c + 5 + 50;

  // {funct7, funct3} of add sub and or xor slt sll srl
  localparam logic [9:0] alu_ops_c [8] = '{10'h000, 10'h100, 10'h007, 10'h006,
                                           10'h004, 10'h002, 10'h001, 10'h005};

  typedef struct packed {
    int          due;
    logic        ill;
    logic [4:0]  addr;
    logic [31:0] data;
  } exp_s;

  logic        clk_i;
  logic        rst_i;
  logic        dispatch_v_i;
  logic [31:0] instr_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic        flush_i;
  logic        wb_v_o;
  logic [4:0]  wb_addr_o;
  logic [31:0] wb_data_o;
  logic        illegal_o;

  logic [31:0] arch_regs [32];
  logic [31:0] pred_regs [32];
  logic [31:0] init_regs [32];
  exp_s        exp_q [$];
  string       test_name = "reset";
  int          cyc = 0;
  int          errors = 0;

  calc_top #(.mul_latency_p(mul_latency_c)) UUT
    (.clk_i(clk_i), .rst_i(rst_i), .dispatch_v_i(dispatch_v_i), .instr_i(instr_i),
     .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i), .flush_i(flush_i),
     .wb_v_o(wb_v_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o),
     .illegal_o(illegal_o));

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Architectural register file of the dispatcher
  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
    if (rst_i)
      for (int i = 0; i < 32; i++)
        arch_regs[i] <= init_regs[i];
    else if (wb_v_o)
      arch_regs[wb_addr_o] <= wb_data_o;
  end

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [4:0] pick_reg(input int lo, input int hi);
    return 5'($urandom_range(hi, lo));
  endfunction

  // Read sees the write of the current cycle and x0 returns a random value
  function automatic logic [31:0] read_arch(input logic [4:0] a);
    if (a == 5'd0)
      return $urandom;
    if (wb_v_o && wb_addr_o == a)
      return wb_data_o;
    return arch_regs[a];
  endfunction

  function automatic void predict(input logic [31:0] instr, output logic ill,
                                  output logic [31:0] res);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    a   = pred_regs[instr[19:15]];
    b   = pred_regs[instr[24:20]];
    imm = {{20{instr[31]}}, instr[31:20]};
    ill = 1'b0;
    res = 32'd0;
    if (instr[6:0] == 7'b0010011 && instr[14:12] == 3'd0)
      res = a + imm;
    else if (instr[6:0] != 7'b0110011)
      ill = 1'b1;
    else if (instr[31:25] == 7'h01 && instr[14:12] == 3'd0)
      res = a * b;
    else if (instr[31:25] == 7'h20 && instr[14:12] == 3'd0)
      res = a - b;
    else if (instr[31:25] != 7'h00 || instr[14:12] == 3'd3)
      ill = 1'b1;
    else
      case (instr[14:12])
        3'd0:    res = a + b;
        3'd1:    res = a << b[4:0];
        3'd2:    res = {31'd0, $signed(a) < $signed(b)};
        3'd4:    res = a ^ b;
        3'd5:    res = a >> b[4:0];
        3'd6:    res = a | b;
        default: res = a & b;
      endcase
  endfunction

  task automatic check_value(input string tname, input string what,
                             input logic [31:0] expv, input logic [31:0] actv);
    if (expv !== actv)
    begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", tname, what, expv, actv);
    end
  endtask

  // Killed instructions are flushed and leave no trace in the model
  task automatic issue(input logic [31:0] instr, input logic kill, input logic flush);
    logic        ill;
    logic [31:0] res;
    dispatch_v_i = 1'b1;
    instr_i      = instr;
    flush_i      = flush;
    rs1_data_i   = read_arch(instr[19:15]);
    rs2_data_i   = read_arch(instr[24:20]);
    if (!kill)
    begin
      predict(instr, ill, res);
      if (ill)
        exp_q.push_back(exp_s'{cyc + mul_latency_c + 2, 1'b1, 5'd0, 32'd0});
      else if (instr[11:7] != 5'd0)
      begin
        pred_regs[instr[11:7]] = res;
        exp_q.push_back(exp_s'{cyc + mul_latency_c + 2, 1'b0, instr[11:7], res});
      end
    end
    @(posedge clk_i);
    #1;
    dispatch_v_i = 1'b0;
    flush_i      = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic test_alu_ops();
    test_name = "test_alu_ops";
    for (int n = 0; n < 27; n++)
    begin
      if (n % 9 == 8)
        issue(itype(12'($urandom), 3'd0, pick_reg(1, 31), pick_reg(1, 31), 7'b0010011),
              1'b0, 1'b0);
      else
        issue(rtype(alu_ops_c[n % 9][9:3], alu_ops_c[n % 9][2:0], pick_reg(1, 31),
                    pick_reg(1, 31), pick_reg(1, 31)), 1'b0, 1'b0);
    end
    idle(drain_c);
  endtask

  // Sources and destinations kept apart so no multiply feeds another too early
  task automatic test_mul();
    test_name = "test_mul";
    for (int n = 0; n < 12; n++)
    begin
      issue(rtype(7'h01, 3'd0, pick_reg(16, 31), pick_reg(1, 15), pick_reg(1, 15)),
            1'b0, 1'b0);
      if (n % 3 == 2)
        idle(1);
    end
    idle(drain_c);
  endtask

  task automatic test_bypass();
    logic [4:0] prev;
    logic [4:0] rd;
    test_name = "test_bypass";
    prev = pick_reg(1, 31);
    for (int n = 0; n < 10; n++)
    begin
      rd = pick_reg(1, 31);
      issue(rtype(alu_ops_c[n % 5][9:3], alu_ops_c[n % 5][2:0], rd, prev,
                  pick_reg(1, 31)), 1'b0, 1'b0);
      prev = rd;
    end
    for (int n = 0; n < 3; n++)
    begin
      rd = pick_reg(1, 31);
      issue(rtype(7'h01, 3'd0, rd, pick_reg(1, 31), pick_reg(1, 31)), 1'b0, 1'b0);
      idle(mul_latency_c - 1);
      issue(rtype(7'h00, 3'd0, pick_reg(1, 31), rd, rd), 1'b0, 1'b0);
    end
    idle(drain_c);
  endtask

  task automatic test_flush();
    logic [4:0] rds [8];
    logic [4:0] rs1;
    test_name = "test_flush";
    for (int n = 0; n < 8; n++)
    begin
      rds[n] = pick_reg(1, 31);
      rs1    = (n >= 6) ? rds[n - 2] : pick_reg(1, 31);
      issue(rtype(7'h00, 3'd0, rds[n], rs1, pick_reg(1, 31)), n >= 3 && n <= 5, n == 5);
    end
    idle(drain_c);
  endtask

  task automatic test_illegal_x0();
    test_name = "test_illegal_x0";
    issue(itype(12'h000, 3'd2, 5'd3, 5'd4, 7'b0000011), 1'b0, 1'b0);
    issue(itype(12'h005, 3'd2, 5'd3, 5'd4, 7'b0010011), 1'b0, 1'b0);
    issue(rtype(7'h00, 3'd3, 5'd3, 5'd4, 5'd5), 1'b0, 1'b0);
    issue(itype(12'h007, 3'd0, 5'd0, 5'd5, 7'b0010011), 1'b0, 1'b0);
    issue(rtype(7'h00, 3'd0, 5'd6, 5'd0, 5'd7), 1'b0, 1'b0);
    issue(rtype(7'h01, 3'd0, 5'd0, 5'd8, 5'd9), 1'b0, 1'b0);
    idle(drain_c);
  endtask

  // Writeback monitor that checks order, latency and contents
  always @(negedge clk_i)
  begin
    exp_s e;
    if (!rst_i)
    begin
      while (exp_q.size() > 0 && exp_q[0].due < cyc)
      begin
        errors++;
        $display("No writeback in %s for entry due at cycle %0d", test_name, exp_q[0].due);
        void'(exp_q.pop_front());
      end
      if (wb_v_o || illegal_o)
      begin
        if (exp_q.size() == 0 || exp_q[0].due != cyc)
        begin
          errors++;
          $display("Writeback in %s at cycle %0d was not expected", test_name, cyc);
        end
        else
        begin
          e = exp_q.pop_front();
          check_value(test_name, "illegal", 32'(e.ill), 32'(illegal_o));
          check_value(test_name, "wb_v", 32'(!e.ill), 32'(wb_v_o));
          if (!e.ill)
          begin
            check_value(test_name, "wb_addr", 32'(e.addr), 32'(wb_addr_o));
            check_value(test_name, "wb_data", e.data, wb_data_o);
          end
        end
      end
    end
  end

  initial
  begin
    wait (cyc >= timeout_c);
    $display("Run stopped after %0d cycles without finishing, %0d errors", cyc, errors);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    void'($urandom(32'he4f6));
    init_regs[0] = 32'd0;
    for (int i = 1; i < 32; i++)
      init_regs[i] = $urandom;
    pred_regs    = init_regs;
    rst_i        = 1'b1;
    dispatch_v_i = 1'b0;
    instr_i      = 32'd0;
    rs1_data_i   = 32'd0;
    rs2_data_i   = 32'd0;
    flush_i      = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    test_alu_ops();
    test_mul();
    test_bypass();
    test_flush();
    test_illegal_x0();
    $display("Run finished with %0d errors", errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
